// File: hdl/mouse_pkg.sv
`default_nettype none

package mouse_pkg;

    ////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////

    // Screen coordinate, 1024x768 fits in 12 bits
    typedef logic [11:0] coord_t;
    // Sign bit from the status byte plus the movement byte
    typedef logic signed [8:0] delta_t;
    // Middle, right, left, as in the status byte
    typedef logic [2:0] button_t;
    typedef logic [2:0] mode_t;

    // Raw view, status byte arrives first
    typedef struct packed {
        logic [7:0] status;
        logic [7:0] x_move;
        logic [7:0] y_move;
    } packet_bytes_t;

    // Decoded view of the same word
    typedef struct packed {
        logic       y_ovf;
        logic       x_ovf;
        logic       y_sign;
        logic       x_sign;
        logic       sync;
        button_t    buttons;
        logic [7:0] x_move;
        logic [7:0] y_move;
    } packet_fields_t;

    typedef union packed {
        packet_bytes_t  packet_bytes;
        packet_fields_t packet_fields;
    } packet_t;

    ////////////////////////////////////////////////////////////
    // Modes and constrainer states
    ////////////////////////////////////////////////////////////

    localparam mode_t MODE_MENU = 3'b000;
    localparam mode_t MODE_GAME = 3'b001;
    // Idle code, marks "no round completed yet"
    localparam mode_t MODE_NONE = 3'b111;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_MENU = 2'd1;
    localparam logic [1:0] ST_GAME = 2'd2;

    ////////////////////////////////////////////////////////////
    // Screen, box and FIFO sizes
    ////////////////////////////////////////////////////////////

    localparam coord_t SCREEN_MAX_X  = 12'd1019;
    localparam coord_t SCREEN_MAX_Y  = 12'd763;
    localparam coord_t BOX_MIN_X     = 12'd361;
    localparam coord_t BOX_MAX_X     = 12'd661;
    localparam coord_t BOX_MIN_Y     = 12'd367;
    localparam coord_t BOX_MAX_Y     = 12'd667;
    localparam coord_t SPRITE_SIZE   = 12'd16;
    localparam coord_t MENU_CENTER_X = 12'd511;
    localparam coord_t MENU_CENTER_Y = 12'd383;
    localparam coord_t BOX_CENTER_X  = 12'd511;
    localparam coord_t BOX_CENTER_Y  = 12'd517;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

// File: hdl/mouse_constrainer.sv
`default_nettype none

module mouse_constrainer (
    input  wire                clk,
    input  wire                rst,
    input  wire mouse_pkg::mode_t mouse_mode,
    output mouse_pkg::coord_t  value,
    output logic               setmax_x,
    output logic               setmax_y,
    output logic               setmin_x,
    output logic               setmin_y,
    output logic               set_x,
    output logic               set_y
);

    import mouse_pkg::*;

    logic [1:0] state;
    logic [1:0] state_nxt;
    // Write index within a round, 0..3 bounds, 4..5 centering
    logic [2:0] step;
    logic [2:0] step_nxt;
    mode_t      last_mode;
    mode_t      last_mode_nxt;
    mode_t      round_mode;
    logic       is_game;
    coord_t     value_nxt;
    // Strobe order max_x, max_y, min_x, min_y, set_x, set_y
    logic [5:0] wr_q;
    logic [5:0] wr_nxt;

    assign is_game    = (state == ST_GAME);
    assign round_mode = is_game ? MODE_GAME : MODE_MENU;

    assign {setmax_x, setmax_y, setmin_x, setmin_y, set_x, set_y} = wr_q;

    ////////////////////////////////////////////////////////////
    // Registered state and outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            step      <= '0;
            last_mode <= MODE_NONE;
            wr_q      <= '0;
            value     <= '0;
        end else begin
            state     <= state_nxt;
            step      <= step_nxt;
            last_mode <= last_mode_nxt;
            wr_q      <= wr_nxt;
            value     <= value_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state and write selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt     = state;
        step_nxt      = '0;
        last_mode_nxt = last_mode;
        wr_nxt        = '0;
        value_nxt     = '0;
        if (state == ST_IDLE) begin
            // Sample the requested mode, anything else stays idle
            if (mouse_mode == MODE_MENU) begin
                state_nxt = ST_MENU;
            end else if (mouse_mode == MODE_GAME) begin
                state_nxt = ST_GAME;
            end
        end else begin
            // One-hot strobe from the step index
            wr_nxt   = 6'b100000 >> step;
            step_nxt = step + 3'd1;
            case (step)
                3'd0: begin
                    // Game max is pulled in by the sprite size
                    value_nxt = is_game ? BOX_MAX_X - SPRITE_SIZE : SCREEN_MAX_X;
                end
                3'd1: begin
                    value_nxt = is_game ? BOX_MAX_Y - SPRITE_SIZE : SCREEN_MAX_Y;
                end
                3'd2: begin
                    value_nxt = is_game ? BOX_MIN_X : '0;
                end
                3'd3: begin
                    value_nxt = is_game ? BOX_MIN_Y : '0;
                end
                3'd4: begin
                    value_nxt = is_game ? BOX_CENTER_X : MENU_CENTER_X;
                end
                default: begin
                    value_nxt = is_game ? BOX_CENTER_Y : MENU_CENTER_Y;
                end
            endcase
            // Round ends after min_y, or after set_y on a mode change
            if ((step == 3'd3 && round_mode == last_mode) || step == 3'd5) begin
                state_nxt     = ST_IDLE;
                step_nxt      = '0;
                last_mode_nxt = round_mode;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/mouse_packet_assembler.sv
`default_nettype none

module mouse_packet_assembler (
    input  wire                clk,
    input  wire                rst,
    input  wire  [7:0]         rx_byte,
    input  wire                rx_valid,
    output logic               push,
    output mouse_pkg::packet_t push_packet,
    output logic               sync_error
);

    import mouse_pkg::*;

    // Next byte position, 0 is the status byte
    logic [1:0] slot;
    // Packet under assembly, complete while push is high
    packet_t    pkt;

    assign push_packet = pkt;

    ////////////////////////////////////////////////////////////
    // Slot counter and strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            slot       <= '0;
            push       <= 1'b0;
            sync_error <= 1'b0;
        end else begin
            push       <= 1'b0;
            sync_error <= 1'b0;
            if (rx_valid) begin
                case (slot)
                    2'd0: begin
                        // Bit 3 of a status byte is always one
                        if (rx_byte[3]) begin
                            slot <= 2'd1;
                        end else begin
                            sync_error <= 1'b1;
                        end
                    end
                    2'd1: begin
                        slot <= 2'd2;
                    end
                    default: begin
                        // Third byte completes the packet
                        slot <= 2'd0;
                        push <= 1'b1;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (slot)
                2'd0: pkt.packet_bytes.status <= rx_byte;
                2'd1: pkt.packet_bytes.x_move <= rx_byte;
                default: pkt.packet_bytes.y_move <= rx_byte;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/packet_fifo.sv
`default_nettype none

module packet_fifo (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       push,
    input  wire mouse_pkg::packet_t   push_packet,
    input  wire                       pop,
    output mouse_pkg::packet_t        head_packet,
    output logic                      fifo_empty,
    output logic                      packet_dropped
);

    import mouse_pkg::*;

    packet_t               mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    // One extra bit so a full buffer is representable
    logic [FIFO_PTR_W:0]   count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full       = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign do_pop     = pop && !fifo_empty;
    // A pop frees the slot in the same cycle
    assign do_push    = push && (!full || do_pop);

    // Discarded packet shows up in the cycle of its push
    assign packet_dropped = push && !do_push;

    assign head_packet = mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Depth is a power of two, pointers wrap on their own
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_packet;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cursor_tracker.sv
`default_nettype none

module cursor_tracker (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mouse_pkg::coord_t    value,
    input  wire                       setmax_x,
    input  wire                       setmax_y,
    input  wire                       setmin_x,
    input  wire                       setmin_y,
    input  wire                       set_x,
    input  wire                       set_y,
    input  wire mouse_pkg::packet_t   head_packet,
    input  wire                       fifo_empty,
    output logic                      pop,
    output mouse_pkg::coord_t         cursor_x,
    output mouse_pkg::coord_t         cursor_y,
    output mouse_pkg::button_t        buttons
);

    import mouse_pkg::*;

    coord_t             min_x;
    coord_t             max_x;
    coord_t             min_y;
    coord_t             max_y;
    logic               any_write;
    // Clamp due after a bound or preset write
    logic               clamp_pend;
    // Sum of a popped packet waits to be clamped
    logic               pkt_pend;
    logic signed [12:0] sum_x;
    logic signed [12:0] sum_y;
    logic signed [12:0] base_x;
    logic signed [12:0] base_y;
    button_t            pkt_buttons;
    coord_t             next_x;
    coord_t             next_y;
    delta_t             dx;
    delta_t             dy;

    // Limit a wide signed sum to lo..hi
    function automatic coord_t clamp(input logic signed [12:0] s,
                                     input coord_t lo,
                                     input coord_t hi);
        if (s > $signed({1'b0, hi})) begin
            return hi;
        end else if (s < $signed({1'b0, lo})) begin
            return lo;
        end
        return s[11:0];
    endfunction

    assign any_write = setmax_x | setmax_y | setmin_x | setmin_y | set_x | set_y;

    // Writes and their clamp go first, packets wait
    assign pop = !fifo_empty && !any_write && !clamp_pend;

    ////////////////////////////////////////////////////////////
    // Packet arithmetic
    ////////////////////////////////////////////////////////////

    assign next_x = clamp(sum_x, min_x, max_x);
    assign next_y = clamp(sum_y, min_y, max_y);

    // Back-to-back packets build on the result still in flight
    assign base_x = $signed({1'b0, pkt_pend ? next_x : cursor_x});
    assign base_y = $signed({1'b0, pkt_pend ? next_y : cursor_y});

    assign dx = {head_packet.packet_fields.x_sign, head_packet.packet_fields.x_move};
    assign dy = {head_packet.packet_fields.y_sign, head_packet.packet_fields.y_move};

    // Sum and button capture in the pop cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            // Overflowed axis keeps its place
            sum_x <= head_packet.packet_fields.x_ovf ? base_x : base_x + dx;
            // PS/2 y grows upward, screen y grows downward
            sum_y <= head_packet.packet_fields.y_ovf ? base_y : base_y - dy;
            pkt_buttons <= head_packet.packet_fields.buttons;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bounds and cursor
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            min_x      <= '0;
            max_x      <= '0;
            min_y      <= '0;
            max_y      <= '0;
            cursor_x   <= '0;
            cursor_y   <= '0;
            buttons    <= '0;
            clamp_pend <= 1'b0;
            pkt_pend   <= 1'b0;
        end else begin
            clamp_pend <= any_write;
            pkt_pend   <= pop;
            if (setmax_x) max_x <= value;
            if (setmax_y) max_y <= value;
            if (setmin_x) min_x <= value;
            if (setmin_y) min_y <= value;
            // Second cycle of a packet
            if (pkt_pend) begin
                cursor_x <= next_x;
                cursor_y <= next_y;
                buttons  <= pkt_buttons;
            end else if (clamp_pend) begin
                cursor_x <= clamp($signed({1'b0, cursor_x}), min_x, max_x);
                cursor_y <= clamp($signed({1'b0, cursor_y}), min_y, max_y);
            end
            // Presets load raw, clamped on the next cycle
            if (set_x) cursor_x <= value;
            if (set_y) cursor_y <= value;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mouse_cursor_top.sv
`default_nettype none

module mouse_cursor_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mouse_pkg::mode_t     mouse_mode,
    input  wire  [7:0]                rx_byte,
    input  wire                       rx_valid,
    output mouse_pkg::coord_t         cursor_x,
    output mouse_pkg::coord_t         cursor_y,
    output mouse_pkg::button_t        buttons,
    output logic                      sync_error,
    output logic                      packet_dropped
);

    import mouse_pkg::*;

    // Bound write bus
    coord_t  value;
    logic    setmax_x;
    logic    setmax_y;
    logic    setmin_x;
    logic    setmin_y;
    logic    set_x;
    logic    set_y;

    // Packet path
    logic    push;
    packet_t push_packet;
    packet_t head_packet;
    logic    fifo_empty;
    logic    pop;

    mouse_constrainer mouse_constrainer_inst (
        .clk        (clk),
        .rst        (rst),
        .mouse_mode (mouse_mode),
        .value      (value),
        .setmax_x   (setmax_x),
        .setmax_y   (setmax_y),
        .setmin_x   (setmin_x),
        .setmin_y   (setmin_y),
        .set_x      (set_x),
        .set_y      (set_y)
    );

    mouse_packet_assembler mouse_packet_assembler_inst (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .push        (push),
        .push_packet (push_packet),
        .sync_error  (sync_error)
    );

    packet_fifo packet_fifo_inst (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .push_packet    (push_packet),
        .pop            (pop),
        .head_packet    (head_packet),
        .fifo_empty     (fifo_empty),
        .packet_dropped (packet_dropped)
    );

    cursor_tracker cursor_tracker_inst (
        .clk         (clk),
        .rst         (rst),
        .value       (value),
        .setmax_x    (setmax_x),
        .setmax_y    (setmax_y),
        .setmin_x    (setmin_x),
        .setmin_y    (setmin_y),
        .set_x       (set_x),
        .set_y       (set_y),
        .head_packet (head_packet),
        .fifo_empty  (fifo_empty),
        .pop         (pop),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .buttons     (buttons)
    );

endmodule

`default_nettype wire

// File: verification/mouse_cursor_properties.sv
`default_nettype none

module mouse_cursor_properties (
    input wire                    clk,
    input wire                    rst,
    input wire                    setmax_x,
    input wire                    setmax_y,
    input wire                    setmin_x,
    input wire                    setmin_y,
    input wire                    set_x,
    input wire                    set_y,
    input wire mouse_pkg::coord_t cursor_x,
    input wire mouse_pkg::coord_t cursor_y,
    input wire mouse_pkg::coord_t min_x,
    input wire mouse_pkg::coord_t max_x,
    input wire mouse_pkg::coord_t min_y,
    input wire mouse_pkg::coord_t max_y,
    input wire                    push,
    input wire                    pop,
    input wire                    packet_dropped
);

    import mouse_pkg::*;

    // Occupancy rebuilt from push and pop traffic
    int   occupancy;
    logic accepted;
    logic removed;

    assign removed  = pop && (occupancy != 0);
    // Full buffer takes a push only alongside a pop
    assign accepted = push && ((occupancy < FIFO_DEPTH) || removed);

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else if (accepted && !removed) begin
            occupancy <= occupancy + 1;
        end else if (removed && !accepted) begin
            occupancy <= occupancy - 1;
        end
    end

    // Bound write strobes never overlap
    strobes_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({setmax_x, setmax_y, setmin_x, setmin_y, set_x, set_y}))
        else $error("more than one bound write strobe is high");

    // Raw presets get one cycle to be clamped
    cursor_x_in_bounds: assert property (@(posedge clk) disable iff (rst)
        $changed(cursor_x) |=> (cursor_x >= min_x && cursor_x <= max_x))
        else $error("cursor_x is outside its bounds after a change");

    cursor_y_in_bounds: assert property (@(posedge clk) disable iff (rst)
        $changed(cursor_y) |=> (cursor_y >= min_y && cursor_y <= max_y))
        else $error("cursor_y is outside its bounds after a change");

    drop_only_when_full: assert property (@(posedge clk) disable iff (rst)
        packet_dropped |-> (occupancy == FIFO_DEPTH))
        else $error("packet dropped while the FIFO had room");

endmodule

bind mouse_cursor_top mouse_cursor_properties mouse_cursor_properties_inst (
    .clk            (clk),
    .rst            (rst),
    .setmax_x       (setmax_x),
    .setmax_y       (setmax_y),
    .setmin_x       (setmin_x),
    .setmin_y       (setmin_y),
    .set_x          (set_x),
    .set_y          (set_y),
    .cursor_x       (cursor_x),
    .cursor_y       (cursor_y),
    .min_x          (cursor_tracker_inst.min_x),
    .max_x          (cursor_tracker_inst.max_x),
    .min_y          (cursor_tracker_inst.min_y),
    .max_y          (cursor_tracker_inst.max_y),
    .push           (push),
    .pop            (pop),
    .packet_dropped (packet_dropped)
);

`default_nettype wire

// File: verification/mouse_cursor_tb.sv
`default_nettype none

module mouse_cursor_tb;

    import mouse_pkg::*;

    localparam int          RESET_CYCLES   = 10;
    localparam int          MODE_WAIT      = 20;
    localparam int          SETTLE_CYCLES  = 10;
    localparam int          CHANGE_TIMEOUT = 60;
    localparam int          DEPTH          = 4;
    localparam logic [31:0] SEED           = 32'hb9736cab;

    // Mode codes, everything past game is idle
    localparam mode_t M_MENU = 3'b000;
    localparam mode_t M_GAME = 3'b001;
    localparam mode_t M_IDLE = 3'b010;

    // Menu covers the screen, game box max pulled in by the 16 pixel sprite
    localparam int MENU_HI_X  = 1019;
    localparam int MENU_HI_Y  = 763;
    localparam int GAME_LO_X  = 361;
    localparam int GAME_HI_X  = 661 - 16;
    localparam int GAME_LO_Y  = 367;
    localparam int GAME_HI_Y  = 667 - 16;
    localparam int MENU_MID_X = 511;
    localparam int MENU_MID_Y = 383;
    localparam int GAME_MID_X = 511;
    localparam int GAME_MID_Y = 517;

    typedef struct {
        string   name;
        mode_t   mode;
        int      dx;
        int      dy;
        bit      x_ovf;
        button_t btn;
        bit      bad_sync;
        int      count;
        int      exp_x;
        int      exp_y;
        button_t exp_btn;
        bit      exp_sync;
        bit      exp_drop;
    } row_t;

    logic       clk;
    logic       rst;
    mode_t      mouse_mode;
    logic [7:0] rx_byte;
    logic       rx_valid;
    coord_t     cursor_x;
    coord_t     cursor_y;
    button_t    buttons;
    logic       sync_error;
    logic       packet_dropped;

    row_t  rows[$];
    mode_t cur_mode;
    int    sync_count;
    int    drop_count;
    int    value_errors;
    int    timeout_errors;

    mouse_cursor_top mouse_cursor_top_inst (
        .clk            (clk),
        .rst            (rst),
        .mouse_mode     (mouse_mode),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .cursor_x       (cursor_x),
        .cursor_y       (cursor_y),
        .buttons        (buttons),
        .sync_error     (sync_error),
        .packet_dropped (packet_dropped)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Pulse counters
    always @(posedge clk) begin
        if (sync_error) begin
            sync_count <= sync_count + 1;
        end
        if (packet_dropped) begin
            drop_count <= drop_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic bit is_active(input mode_t m);
        return (m == M_MENU) || (m == M_GAME);
    endfunction

    function automatic int clamp_int(input int v, input int lo, input int hi);
        if (v < lo) begin
            return lo;
        end
        return (v > hi) ? hi : v;
    endfunction

    task automatic add_row(input string name, input mode_t mode, input int dx, input int dy,
                           input bit x_ovf, input button_t btn, input bit bad_sync,
                           input int count);
        row_t r;
        r.name     = name;
        r.mode     = mode;
        r.dx       = dx;
        r.dy       = dy;
        r.x_ovf    = x_ovf;
        r.btn      = btn;
        r.bad_sync = bad_sync;
        r.count    = count;
        rows.push_back(r);
    endtask

    // Walk the table once and fill in the expected columns
    task automatic fill_expected();
        int      lo_x;
        int      hi_x;
        int      lo_y;
        int      hi_y;
        int      x;
        int      y;
        int      taken;
        button_t btn;
        mode_t   last;
        bit      have_last;
        lo_x      = 0;
        hi_x      = 0;
        lo_y      = 0;
        hi_y      = 0;
        x         = 0;
        y         = 0;
        btn       = '0;
        last      = M_IDLE;
        have_last = 1'b0;
        foreach (rows[i]) begin
            if (is_active(rows[i].mode)) begin
                lo_x = (rows[i].mode == M_GAME) ? GAME_LO_X : 0;
                hi_x = (rows[i].mode == M_GAME) ? GAME_HI_X : MENU_HI_X;
                lo_y = (rows[i].mode == M_GAME) ? GAME_LO_Y : 0;
                hi_y = (rows[i].mode == M_GAME) ? GAME_HI_Y : MENU_HI_Y;
                // Centered only when the active mode changes
                if (!have_last || rows[i].mode != last) begin
                    x = (rows[i].mode == M_GAME) ? GAME_MID_X : MENU_MID_X;
                    y = (rows[i].mode == M_GAME) ? GAME_MID_Y : MENU_MID_Y;
                end else begin
                    x = clamp_int(x, lo_x, hi_x);
                    y = clamp_int(y, lo_y, hi_y);
                end
                last      = rows[i].mode;
                have_last = 1'b1;
            end
            // Tracker is locked out while rounds run, the FIFO only holds DEPTH
            taken = rows[i].count;
            if (is_active(rows[i].mode) && taken > DEPTH) begin
                taken = DEPTH;
            end
            for (int k = 0; k < taken; k++) begin
                if (!rows[i].x_ovf) begin
                    x = clamp_int(x + rows[i].dx, lo_x, hi_x);
                end
                // Screen y grows downward
                y   = clamp_int(y - rows[i].dy, lo_y, hi_y);
                btn = rows[i].btn;
            end
            rows[i].exp_x    = x;
            rows[i].exp_y    = y;
            rows[i].exp_btn  = btn;
            rows[i].exp_sync = rows[i].bad_sync;
            rows[i].exp_drop = is_active(rows[i].mode) && (rows[i].count > DEPTH);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_coord(input string name, input coord_t expected, input coord_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_buttons(input string name, input button_t expected,
                                 input button_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        rx_byte  <= b;
        rx_valid <= 1'b1;
    endtask

    task automatic send_packet(input row_t r);
        logic [8:0] dx9;
        logic [8:0] dy9;
        dx9 = r.dx[8:0];
        dy9 = r.dy[8:0];
        // Misaligned status byte, sync bit clear
        if (r.bad_sync) begin
            send_byte({5'b00000, r.btn});
        end
        send_byte({1'b0, r.x_ovf, dy9[8], dx9[8], 1'b1, r.btn});
        send_byte(dx9[7:0]);
        send_byte(dy9[7:0]);
    endtask

    task automatic set_mode(input mode_t m);
        @(posedge clk);
        mouse_mode <= m;
        cur_mode = m;
        repeat (MODE_WAIT) @(posedge clk);
    endtask

    task automatic wait_update(input string name, input coord_t px, input coord_t py,
                               input button_t pb, input bit expect_change);
        bit seen;
        seen = 1'b0;
        if (expect_change) begin
            for (int n = 0; n < CHANGE_TIMEOUT && !seen; n++) begin
                @(posedge clk);
                seen = (cursor_x != px) || (cursor_y != py) || (buttons != pb);
            end
            if (!seen) begin
                $display("Timeout in %s, cursor and buttons never changed", name);
                timeout_errors++;
            end
        end else begin
            repeat (SETTLE_CYCLES) @(posedge clk);
        end
    endtask

    task automatic apply_row(input row_t r, input bit expect_change);
        coord_t  px;
        coord_t  py;
        button_t pb;
        int      sync0;
        int      drop0;
        if (r.mode != cur_mode) begin
            set_mode(r.mode);
        end
        px    = cursor_x;
        py    = cursor_y;
        pb    = buttons;
        sync0 = sync_count;
        drop0 = drop_count;
        for (int k = 0; k < r.count; k++) begin
            send_packet(r);
        end
        if (r.count > 0) begin
            @(posedge clk);
            rx_valid <= 1'b0;
            // Packets queued during rounds drain once the mode goes idle
            if (is_active(cur_mode)) begin
                set_mode(M_IDLE);
            end else begin
                wait_update(r.name, px, py, pb, expect_change);
            end
        end else begin
            repeat (SETTLE_CYCLES) @(posedge clk);
        end
        check_coord({r.name, " cursor_x"}, coord_t'(r.exp_x), cursor_x);
        check_coord({r.name, " cursor_y"}, coord_t'(r.exp_y), cursor_y);
        check_buttons({r.name, " buttons"}, r.exp_btn, buttons);
        check_flag({r.name, " sync_error"}, r.exp_sync, sync_count != sync0);
        check_flag({r.name, " packet_dropped"}, r.exp_drop, drop_count != drop0);
    endtask

    task automatic build_table();
        add_row("menu_center", M_MENU, 0, 0, 0, 3'b000, 0, 0);
        add_row("menu_right", M_IDLE, 255, 0, 0, 3'b000, 0, 1);
        add_row("menu_right_clamp", M_IDLE, 255, 0, 0, 3'b000, 0, 1);
        add_row("menu_down", M_IDLE, 0, -256, 0, 3'b000, 0, 1);
        add_row("menu_down_clamp", M_IDLE, 0, -256, 0, 3'b000, 0, 1);
        add_row("game_center", M_GAME, 0, 0, 0, 3'b000, 0, 0);
        for (int n = 0; n < 8; n++) begin
            add_row($sformatf("game_random_%0d", n), M_IDLE, int'($urandom % 512) - 256,
                    int'($urandom % 512) - 256, 0, button_t'($urandom % 8), 0, 1);
        end
        add_row("buttons_lr", M_IDLE, 5, 3, 0, 3'b011, 0, 1);
        add_row("x_overflow", M_IDLE, 40, -20, 1, 3'b100, 0, 1);
        add_row("sync_recover", M_IDLE, -30, 10, 0, 3'b001, 1, 1);
        // Six packets into a four deep FIFO while the tracker is locked out
        add_row("burst_drop", M_GAME, 40, -30, 0, 3'b010, 0, 6);
        add_row("idle_hold", M_IDLE, 0, 0, 0, 3'b000, 0, 0);
        add_row("menu_recenter", M_MENU, 0, 0, 0, 3'b000, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int      seed_ret;
        int      prev_x;
        int      prev_y;
        button_t prev_btn;
        bit      change;
        rst        = 1'b1;
        mouse_mode = M_IDLE;
        rx_byte    = 8'h00;
        rx_valid   = 1'b0;
        cur_mode   = M_IDLE;
        seed_ret   = $urandom(SEED);
        build_table();
        fill_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        prev_x   = 0;
        prev_y   = 0;
        prev_btn = '0;
        foreach (rows[i]) begin
            change = (rows[i].exp_x != prev_x) || (rows[i].exp_y != prev_y) ||
                     (rows[i].exp_btn != prev_btn);
            apply_row(rows[i], change);
            prev_x   = rows[i].exp_x;
            prev_y   = rows[i].exp_y;
            prev_btn = rows[i].exp_btn;
        end
        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/mouse_pkg.sv
hdl/mouse_constrainer.sv
hdl/mouse_packet_assembler.sv
hdl/packet_fifo.sv
hdl/cursor_tracker.sv
hdl/mouse_cursor_top.sv
verification/mouse_cursor_properties.sv
verification/mouse_cursor_tb.sv
